//--- Bender.yml
package:
  name: pipe_trace

sources:
  - design/trace_pkg.sv
  - design/trace_sync_fifo.sv
  - design/pipe_event_capture.sv
  - design/event_serializer.sv
  - design/trace_credit_tx.sv
  - design/pipe_trace_top.sv
  - target: test
    files:
      - testbench/pipe_trace_checker.sv
      - testbench/pipe_trace_tb.sv

//--- design/event_serializer.sv
// Emits one record per free clock from the head snapshot in ascending slot order
`timescale 1ns/10ps
`default_nettype none

module event_serializer (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            snap_valid,
  input  logic [trace_pkg::STAMP_W-1:0]                   snap_stamp,
  input  logic [trace_pkg::KIND_W*trace_pkg::EV_SLOTS-1:0] snap_kinds,
  input  logic [trace_pkg::EV_SLOTS-1:0]                  snap_mask,
  input  logic [trace_pkg::EV_SLOTS*trace_pkg::INST_ID_W-1:0] snap_ids,
  output logic                                            snap_pop,
  output logic                                            rec_push,
  output logic [trace_pkg::REC_W-1:0]                     rec_in,
  input  logic                                            rec_full
);

  import trace_pkg::*;

  typedef enum logic {
    SER_IDLE,
    SER_EMIT
  } ser_state_t;

  ser_state_t          state;
  logic [EV_SLOTS-1:0] rem;
  logic [EV_SLOTS-1:0] cur;
  logic [EV_SLOTS-1:0] rest;
  logic [SLOT_W-1:0]   sel;
  logic                active;

  // Fresh head uses its own mask, a partly sent one the remainder
  assign cur    = (state == SER_EMIT) ? rem : snap_mask;
  assign active = (state == SER_EMIT) || snap_valid;

  always_comb begin
    sel = '0;
    for (int i = EV_SLOTS - 1; i >= 0; i--) begin
      if (cur[i]) begin
        sel = SLOT_W'(i);
      end
    end
  end

  assign rest = cur & ~(EV_SLOTS'(1) << sel);

  assign rec_push = active && !rec_full;
  assign snap_pop = rec_push && (rest == '0);
  assign rec_in   = {snap_stamp,
                     snap_kinds[KIND_W*sel +: KIND_W],
                     sel,
                     snap_ids[INST_ID_W*sel +: INST_ID_W]};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SER_IDLE;
    end else if (rec_push) begin
      state <= (rest == '0) ? SER_IDLE : SER_EMIT;
    end
  end

  always_ff @(posedge clk) begin
    if (rec_push) begin
      rem <= rest;
    end
  end

  // Capture never queues a snapshot without events
  a_mask_nonzero: assert property (@(posedge clk) disable iff (rst)
    (snap_valid && (state == SER_IDLE)) |-> (snap_mask != '0))
    else $error("empty snapshot at the head");

  // Partly sent snapshot must still be at the head
  a_head_held: assert property (@(posedge clk) disable iff (rst)
    (state == SER_EMIT) |-> snap_valid)
    else $error("snapshot lost during emission");

endmodule

`default_nettype wire

//--- design/pipe_event_capture.sv
// Inputs are sampled one edge early and a full snapshot FIFO drops the whole cycle
`timescale 1ns/10ps
`default_nettype none

module pipe_event_capture (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [trace_pkg::N_STAGES-1:0]               stage_valid,
  input  logic [trace_pkg::N_STAGES-1:0]               stage_stall,
  input  logic [trace_pkg::N_STAGES-1:0]               stage_flush,
  input  logic [trace_pkg::N_STAGES*trace_pkg::INST_ID_W-1:0] stage_id,
  input  logic                                         wb_valid,
  input  logic [trace_pkg::INST_ID_W-1:0]              wb_id,
  output logic                                         snap_valid,
  output logic [trace_pkg::STAMP_W-1:0]                snap_stamp,
  output logic [trace_pkg::KIND_W*trace_pkg::EV_SLOTS-1:0] snap_kinds,
  output logic [trace_pkg::EV_SLOTS-1:0]               snap_mask,
  output logic [trace_pkg::EV_SLOTS*trace_pkg::INST_ID_W-1:0] snap_ids,
  input  logic                                         snap_pop,
  output logic [trace_pkg::DROP_W-1:0]                 dropped_count
);

  import trace_pkg::*;

  logic [STAMP_W-1:0]            cyc;
  logic [N_STAGES-1:0]           r_valid;
  logic [N_STAGES-1:0]           r_stall;
  logic [N_STAGES-1:0]           r_flush;
  logic [N_STAGES*INST_ID_W-1:0] r_stage_id;
  logic                          r_wb_valid;
  logic [INST_ID_W-1:0]          r_wb_id;
  logic [STAMP_W-1:0]            r_stamp;

  logic [KIND_W*EV_SLOTS-1:0]    kinds_c;
  logic [EV_SLOTS-1:0]           mask_c;
  logic [SNAP_W-1:0]             snap_word;
  logic                          fifo_full;
  logic                          fifo_empty;
  logic                          has_event;

  // Sample stage
  always_ff @(posedge clk) begin
    if (rst) begin
      cyc        <= '0;
      r_valid    <= '0;
      r_flush    <= '0;
      r_wb_valid <= 1'b0;
    end else begin
      cyc        <= cyc + 1'b1;
      r_valid    <= stage_valid;
      r_flush    <= stage_flush;
      r_wb_valid <= wb_valid;
    end
  end

  always_ff @(posedge clk) begin
    r_stall    <= stage_stall;
    r_stage_id <= stage_id;
    r_wb_id    <= wb_id;
    r_stamp    <= cyc;
  end

  // Flush wins over stall, stall over enter
  always_comb begin
    kinds_c = '0;
    mask_c  = '0;
    for (int s = 0; s < N_STAGES; s++) begin
      if (r_flush[s]) begin
        kinds_c[KIND_W*s +: KIND_W] = TK_FLUSH;
        mask_c[s] = 1'b1;
      end else if (r_valid[s]) begin
        kinds_c[KIND_W*s +: KIND_W] = r_stall[s] ? TK_STALL : TK_ENTER;
        mask_c[s] = 1'b1;
      end
    end
    kinds_c[KIND_W*SLOT_WB +: KIND_W] = TK_RETIRE;
    mask_c[SLOT_WB] = r_wb_valid;
  end

  assign has_event = |mask_c;
  assign snap_word = {r_stamp, kinds_c, mask_c, r_wb_id, r_stage_id};

  trace_sync_fifo #(
    .WIDTH (SNAP_W),
    .DEPTH (SNAP_DEPTH)
  ) u_snap_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (has_event && !fifo_full),
    .din   (snap_word),
    .pop   (snap_pop),
    .dout  ({snap_stamp, snap_kinds, snap_mask, snap_ids}),
    .empty (fifo_empty),
    .full  (fifo_full)
  );

  assign snap_valid = !fifo_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      dropped_count <= '0;
    end else if (has_event && fifo_full && (dropped_count != '1)) begin
      dropped_count <= dropped_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/pipe_trace_top.sv
// Trace collector top with credit flow control toward the sink
`timescale 1ns/10ps
`default_nettype none

module pipe_trace_top (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [trace_pkg::N_STAGES-1:0]               stage_valid,
  input  logic [trace_pkg::N_STAGES-1:0]               stage_stall,
  input  logic [trace_pkg::N_STAGES-1:0]               stage_flush,
  input  logic [trace_pkg::N_STAGES*trace_pkg::INST_ID_W-1:0] stage_id,
  input  logic                                         wb_valid,
  input  logic [trace_pkg::INST_ID_W-1:0]              wb_id,
  output logic                                         rec_valid,
  output logic [trace_pkg::REC_W-1:0]                  rec_data,
  input  logic                                         credit_return,
  output logic [trace_pkg::DROP_W-1:0]                 dropped_count
);

  import trace_pkg::*;

  logic                       snap_valid;
  logic [STAMP_W-1:0]         snap_stamp;
  logic [KIND_W*EV_SLOTS-1:0] snap_kinds;
  logic [EV_SLOTS-1:0]        snap_mask;
  logic [EV_SLOTS*INST_ID_W-1:0] snap_ids;
  logic                       snap_pop;
  logic                       rec_push;
  logic [REC_W-1:0]           rec_in;
  logic                       rec_full;

  pipe_event_capture u_capture (
    .clk           (clk),
    .rst           (rst),
    .stage_valid   (stage_valid),
    .stage_stall   (stage_stall),
    .stage_flush   (stage_flush),
    .stage_id      (stage_id),
    .wb_valid      (wb_valid),
    .wb_id         (wb_id),
    .snap_valid    (snap_valid),
    .snap_stamp    (snap_stamp),
    .snap_kinds    (snap_kinds),
    .snap_mask     (snap_mask),
    .snap_ids      (snap_ids),
    .snap_pop      (snap_pop),
    .dropped_count (dropped_count)
  );

  event_serializer u_serializer (
    .clk        (clk),
    .rst        (rst),
    .snap_valid (snap_valid),
    .snap_stamp (snap_stamp),
    .snap_kinds (snap_kinds),
    .snap_mask  (snap_mask),
    .snap_ids   (snap_ids),
    .snap_pop   (snap_pop),
    .rec_push   (rec_push),
    .rec_in     (rec_in),
    .rec_full   (rec_full)
  );

  trace_credit_tx u_tx (
    .clk           (clk),
    .rst           (rst),
    .rec_push      (rec_push),
    .rec_in        (rec_in),
    .rec_full      (rec_full),
    .rec_valid     (rec_valid),
    .rec_data      (rec_data),
    .credit_return (credit_return)
  );

endmodule

`default_nettype wire

//--- design/trace_credit_tx.sv
// Sink must return no more credits than it was given
`timescale 1ns/10ps
`default_nettype none

module trace_credit_tx (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rec_push,
  input  logic [trace_pkg::REC_W-1:0] rec_in,
  output logic                        rec_full,
  output logic                        rec_valid,
  output logic [trace_pkg::REC_W-1:0] rec_data,
  input  logic                        credit_return
);

  import trace_pkg::*;

  logic [CREDIT_W-1:0] credits;
  logic                fifo_empty;

  trace_sync_fifo #(
    .WIDTH (REC_W),
    .DEPTH (REC_DEPTH)
  ) u_rec_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (rec_push),
    .din   (rec_in),
    .pop   (rec_valid),
    .dout  (rec_data),
    .empty (fifo_empty),
    .full  (rec_full)
  );

  // Each send spends a credit
  assign rec_valid = !fifo_empty && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CREDIT_W'(TRACE_CREDITS);
    end else begin
      case ({rec_valid, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= CREDIT_W'(TRACE_CREDITS))
    else $error("credit count above sink capacity");

  a_return_owed: assert property (@(posedge clk) disable iff (rst)
    credit_return |-> (credits != CREDIT_W'(TRACE_CREDITS)))
    else $error("credit returned while none was outstanding");

endmodule

`default_nettype wire

//--- design/trace_pkg.sv
// Shared widths and depths of the trace collector with records laid out as stamp kind slot id from the top
`default_nettype none

package trace_pkg;

  // Traced pipeline stages if1 if2 id ir rr exe
  localparam int N_STAGES = 6;
  // One extra slot for the merged writeback port
  localparam int EV_SLOTS = N_STAGES + 1;

  localparam int INST_ID_W = 16;
  // Cycle stamp wraps around
  localparam int STAMP_W   = 16;
  localparam int SLOT_W    = 3;
  localparam int KIND_W    = 2;

  // Slot codes 0 to 5 follow stage order
  localparam logic [SLOT_W-1:0] SLOT_WB = 3'd6;

  typedef enum logic [KIND_W-1:0] {
    TK_ENTER  = 2'd0,
    TK_STALL  = 2'd1,
    TK_FLUSH  = 2'd2,
    TK_RETIRE = 2'd3
  } trace_kind_t;

  localparam int REC_W = STAMP_W + KIND_W + SLOT_W + INST_ID_W;

  // Snapshot word is stamp then kinds then mask then ids
  localparam int SNAP_W = STAMP_W + KIND_W * EV_SLOTS + EV_SLOTS + INST_ID_W * EV_SLOTS;

  localparam int SNAP_DEPTH = 4;
  localparam int REC_DEPTH  = 8;

  // Sink buffer size and credits after reset
  localparam int TRACE_CREDITS = 4;
  localparam int CREDIT_W      = $clog2(TRACE_CREDITS + 1);

  // Saturating drop counter
  localparam int DROP_W = 16;

endpackage

`default_nettype wire

//--- design/trace_sync_fifo.sv
// DEPTH of at least 2 is assumed and the user must never push a full or pop an empty FIFO
`timescale 1ns/10ps
`default_nettype none

module trace_sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] din,
  input  logic             pop,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head entry straight from the array
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("push into full FIFO");
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("pop from empty FIFO");

endmodule

`default_nettype wire

//--- pipe_trace_top.f
design/trace_pkg.sv
design/trace_sync_fifo.sv
design/pipe_event_capture.sv
design/event_serializer.sv
design/trace_credit_tx.sv
design/pipe_trace_top.sv
testbench/pipe_trace_checker.sv
testbench/pipe_trace_tb.sv

//--- testbench/pipe_trace_checker.sv
// Reference model assumes a single reset at the start and stamps that stay unique among snapshots in flight
`timescale 1ns/10ps
`default_nettype none

module pipe_trace_checker (
  input logic                                                clk,
  input logic                                                rst,
  input logic [trace_pkg::N_STAGES-1:0]                      stage_valid,
  input logic [trace_pkg::N_STAGES-1:0]                      stage_stall,
  input logic [trace_pkg::N_STAGES-1:0]                      stage_flush,
  input logic [trace_pkg::N_STAGES*trace_pkg::INST_ID_W-1:0] stage_id,
  input logic                                                wb_valid,
  input logic [trace_pkg::INST_ID_W-1:0]                     wb_id,
  input logic                                                rec_valid,
  input logic [trace_pkg::REC_W-1:0]                         rec_data,
  input logic [trace_pkg::DROP_W-1:0]                        dropped_count
);

  import trace_pkg::*;

  logic [REC_W-1:0]   exp_q[$];
  int                 snap_len_q[$];
  int                 pos = 0;
  logic [STAMP_W-1:0] stamp = '0;
  string              test_name = "none";
  int                 errors = 0;
  int                 total_errors = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 removed = 0;
  int                 rec_count = 0;
  logic [DROP_W-1:0]  drop_base = '0;

  function automatic logic [REC_W-1:0] make_rec(input logic [STAMP_W-1:0] st,
                                                input logic [KIND_W-1:0] kind,
                                                input int slot,
                                                input logic [INST_ID_W-1:0] id);
    return {st, kind, SLOT_W'(slot), id};
  endfunction

  task automatic note_error(input string msg);
    errors++;
    total_errors++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  task automatic check_value(input string what, input int exp, input int act);
    if (exp != act) begin
      errors++;
      total_errors++;
      $display("FAIL %s %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  // Flush first, then stall, then plain enter; writeback last
  task automatic capture_snapshot();
    int n;
    n = 0;
    for (int s = 0; s < N_STAGES; s++) begin
      if (stage_flush[s]) begin
        exp_q.push_back(make_rec(stamp, TK_FLUSH, s, stage_id[INST_ID_W*s +: INST_ID_W]));
        n++;
      end else if (stage_valid[s]) begin
        exp_q.push_back(make_rec(stamp, stage_stall[s] ? TK_STALL : TK_ENTER, s,
                                 stage_id[INST_ID_W*s +: INST_ID_W]));
        n++;
      end
    end
    if (wb_valid) begin
      exp_q.push_back(make_rec(stamp, TK_RETIRE, N_STAGES, wb_id));
      n++;
    end
    if (n != 0) begin
      snap_len_q.push_back(n);
    end
  endtask

  task automatic drop_head();
    int n;
    n = snap_len_q.pop_front();
    repeat (n) void'(exp_q.pop_front());
    removed++;
  endtask

  task automatic check_record(input logic [REC_W-1:0] act);
    int off;
    int hit;
    rec_count++;
    if (exp_q.size() == 0) begin
      note_error($sformatf("record %h arrived while none was expected", act));
    end else begin
      // Dropped snapshots show up as a jump in the stamp
      if (pos == 0) begin
        off = 0;
        hit = -1;
        for (int k = 0; k < snap_len_q.size() && hit < 0; k++) begin
          if (exp_q[off][REC_W-1 -: STAMP_W] == act[REC_W-1 -: STAMP_W]) begin
            hit = k;
          end
          off += snap_len_q[k];
        end
        if (hit > 0) begin
          repeat (hit) drop_head();
        end
      end
      if (act !== exp_q[0]) begin
        errors++;
        total_errors++;
        $display("FAIL %s expected %h actual %h", test_name, exp_q[0], act);
      end
      void'(exp_q.pop_front());
      pos++;
      if (pos == snap_len_q[0]) begin
        void'(snap_len_q.pop_front());
        pos = 0;
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors    = 0;
    removed   = 0;
    rec_count = 0;
    pos       = 0;
    drop_base = dropped_count;
    exp_q.delete();
    snap_len_q.delete();
  endtask

  task automatic finish_test(input bit no_drops);
    int drops;
    if (pos != 0) begin
      note_error("a snapshot was only partly received");
      repeat (snap_len_q[0] - pos) void'(exp_q.pop_front());
      void'(snap_len_q.pop_front());
      pos = 0;
    end
    // Anything still queued never arrived
    while (snap_len_q.size() != 0) begin
      drop_head();
    end
    drops = int'(DROP_W'(dropped_count - drop_base));
    check_value("dropped snapshots", removed, drops);
    if (no_drops) begin
      check_value("dropped_count", 0, drops);
    end
    tests_run++;
    if (errors != 0) begin
      tests_failed++;
    end
    $display("test %-12s %s  records %0d  dropped %0d", test_name,
             (errors == 0) ? "passed" : "failed", rec_count, drops);
  endtask

  task automatic report_counts();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      stamp = '0;
    end else begin
      capture_snapshot();
      stamp = stamp + 1'b1;
      if (rec_valid === 1'b1) begin
        check_record(rec_data);
      end else if (rec_valid !== 1'b0) begin
        note_error("rec_valid is unknown");
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/pipe_trace_tb.sv
// One reset at time zero; the stamp wrap test alone runs for over 65536 cycles
`timescale 1ns/10ps
`default_nettype none

module pipe_trace_tb;

  import trace_pkg::*;

  localparam int RST_CYC    = 5;
  localparam int T1_CYC     = 20;
  localparam int T2_CYC     = 2 * (N_STAGES * 8 + 2);
  localparam int T3_CYC     = 800;
  localparam int STARVE_CYC = 60;
  localparam int T4_CYC     = 2 + STARVE_CYC;
  localparam int T5_CYC     = 300;
  localparam int T6_CYC     = 70000;
  localparam int N_TESTS    = 6;
  localparam int DRAIN_CYC  = 200;
  localparam int QUIET_CYC  = 16;
  localparam int LIMIT_CYC  = RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC
                              + T6_CYC + (N_TESTS + 1) * DRAIN_CYC;

  logic                          clk;
  logic                          rst;
  logic [N_STAGES-1:0]           stage_valid;
  logic [N_STAGES-1:0]           stage_stall;
  logic [N_STAGES-1:0]           stage_flush;
  logic [N_STAGES*INST_ID_W-1:0] stage_id;
  logic                          wb_valid;
  logic [INST_ID_W-1:0]          wb_id;
  logic                          credit_return = 1'b0;
  logic                          rec_valid;
  logic [REC_W-1:0]              rec_data;
  logic [DROP_W-1:0]             dropped_count;

  // Sink buffer and credit pacing
  logic [REC_W-1:0] sink_q[$];
  // A period of 0 holds credits back
  int               credit_period = 1;
  int               tick = 0;
  int               quiet = 0;
  int               rx_count = 0;

  pipe_trace_top uut (
    .clk           (clk),
    .rst           (rst),
    .stage_valid   (stage_valid),
    .stage_stall   (stage_stall),
    .stage_flush   (stage_flush),
    .stage_id      (stage_id),
    .wb_valid      (wb_valid),
    .wb_id         (wb_id),
    .rec_valid     (rec_valid),
    .rec_data      (rec_data),
    .credit_return (credit_return),
    .dropped_count (dropped_count)
  );

  pipe_trace_checker chk (
    .clk           (clk),
    .rst           (rst),
    .stage_valid   (stage_valid),
    .stage_stall   (stage_stall),
    .stage_flush   (stage_flush),
    .stage_id      (stage_id),
    .wb_valid      (wb_valid),
    .wb_id         (wb_id),
    .rec_valid     (rec_valid),
    .rec_data      (rec_data),
    .dropped_count (dropped_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic drive_cycle(input logic [N_STAGES-1:0] v, input logic [N_STAGES-1:0] s,
                             input logic [N_STAGES-1:0] f, input logic wv);
    logic [N_STAGES*INST_ID_W-1:0] ids;
    for (int i = 0; i < N_STAGES; i++) begin
      ids[INST_ID_W*i +: INST_ID_W] = INST_ID_W'($urandom);
    end
    @(posedge clk);
    stage_valid <= v;
    stage_stall <= s;
    stage_flush <= f;
    stage_id    <= ids;
    wb_valid    <= wv;
    wb_id       <= INST_ID_W'($urandom);
  endtask

  task automatic drive_idle();
    drive_cycle('0, '0, '0, 1'b0);
  endtask

  // Flush on roughly one stage in eight
  task automatic drive_random();
    logic [N_STAGES-1:0] f;
    f = N_STAGES'($urandom & $urandom & $urandom);
    drive_cycle(N_STAGES'($urandom), N_STAGES'($urandom), f, 1'($urandom));
  endtask

  task automatic drain();
    int n;
    drive_idle();
    @(negedge clk);
    credit_period = 1;
    n = 0;
    while ((quiet < QUIET_CYC || sink_q.size() != 0) && n < DRAIN_CYC) begin
      @(negedge clk);
      n++;
    end
    if (n >= DRAIN_CYC) begin
      chk.note_error("records were still arriving at the end of the drain window");
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      credit_return <= 1'b0;
      sink_q.delete();
      tick  = 0;
      quiet = 0;
    end else begin
      credit_return <= 1'b0;
      if (rec_valid === 1'b1) begin
        sink_q.push_back(rec_data);
        rx_count++;
        if (sink_q.size() > TRACE_CREDITS) begin
          chk.note_error("sink buffer overflow, a record was sent without a credit");
        end
      end
      if (rec_valid === 1'b1 || stage_valid != '0 || stage_flush != '0 || wb_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      if (credit_period != 0) begin
        tick++;
        if (tick >= credit_period && sink_q.size() != 0) begin
          credit_return <= 1'b1;
          void'(sink_q.pop_front());
          tick = 0;
        end
      end
    end
  end

  initial begin
    repeat (LIMIT_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles with tests still running", LIMIT_CYC);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    logic [N_STAGES-1:0] bits;
    int                  gap;
    int                  base;
    void'($urandom(32'hde2ac317));
    rst         = 1'b1;
    stage_valid = '0;
    stage_stall = '0;
    stage_flush = '0;
    stage_id    = '0;
    wb_valid    = 1'b0;
    wb_id       = '0;
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    chk.start_test("reset_idle");
    chk.check_value("dropped_count after reset", 0, int'(dropped_count));
    repeat (T1_CYC) drive_idle();
    drain();
    chk.finish_test(1'b1);

    // Every valid, stall and flush mix on one stage at a time
    chk.start_test("directed");
    for (int slot = 0; slot < N_STAGES; slot++) begin
      for (int c = 0; c < 8; c++) begin
        bits = N_STAGES'(1) << slot;
        drive_cycle(c[0] ? bits : '0, c[1] ? bits : '0, c[2] ? bits : '0, 1'b0);
        drive_idle();
      end
    end
    drive_cycle('0, '0, '0, 1'b0);
    drive_idle();
    drive_cycle('0, '0, '0, 1'b1);
    drive_idle();
    drain();
    chk.finish_test(1'b1);

    chk.start_test("random_free");
    gap = 0;
    for (int i = 0; i < T3_CYC; i++) begin
      if (gap == 0) begin
        drive_random();
        gap = 7 + $urandom_range(3);
      end else begin
        drive_idle();
        gap--;
      end
    end
    drain();
    chk.finish_test(1'b1);

    chk.start_test("starvation");
    credit_period = 0;
    base = rx_count;
    drive_cycle('1, '0, '0, 1'b1);
    drive_cycle('1, '1, '0, 1'b1);
    repeat (STARVE_CYC) drive_idle();
    @(negedge clk);
    chk.check_value("records without credit return", TRACE_CREDITS, rx_count - base);
    drain();
    chk.finish_test(1'b1);

    chk.start_test("overload");
    credit_period = 6;
    repeat (T5_CYC) drive_random();
    drain();
    chk.finish_test(1'b0);

    chk.start_test("stamp_wrap");
    credit_period = 1;
    for (int i = 0; i < T6_CYC; i++) begin
      if ($urandom_range(7) == 0) begin
        drive_random();
      end else begin
        drive_idle();
      end
    end
    drain();
    chk.finish_test(1'b0);

    chk.report_counts();
    if (chk.total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
